// ==== hw/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  reg_idx_t;

  localparam reg_idx_t reg_pc   = 4'd15;
  localparam reg_idx_t reg_link = 4'd14;

  // data-processing opcodes, instruction bits 24:21
  typedef enum logic [3:0] {
    op_and = 4'b0000,
    op_eor = 4'b0001,
    op_sub = 4'b0010,
    op_rsb = 4'b0011,
    op_add = 4'b0100,
    op_adc = 4'b0101,
    op_sbc = 4'b0110,
    op_rsc = 4'b0111,
    op_tst = 4'b1000,
    op_teq = 4'b1001,
    op_cmp = 4'b1010,
    op_cmn = 4'b1011,
    op_orr = 4'b1100,
    op_mov = 4'b1101,
    op_bic = 4'b1110,
    op_mvn = 4'b1111
  } opcode_e;

  // condition field, bits 31:28
  typedef enum logic [3:0] {
    cond_eq = 4'b0000,
    cond_ne = 4'b0001,
    cond_cs = 4'b0010,
    cond_cc = 4'b0011,
    cond_mi = 4'b0100,
    cond_pl = 4'b0101,
    cond_al = 4'b1110
  } cond_e;

  // instruction class, bits 27:26
  typedef enum logic [1:0] {
    kind_data_proc = 2'b00,
    kind_ldr_str   = 2'b01,
    kind_branch    = 2'b10
  } inst_kind_e;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
  } flags_t;

  typedef struct packed {
    logic       en;
    logic [7:0] addr;
    word_t      data;
  } prog_write_t;

  typedef struct packed {
    logic       valid;
    inst_kind_e kind;
    opcode_e    opcode;
    logic       set_flags;
    logic       is_load;
    logic       is_link;
    cond_e      cond;
    reg_idx_t   rn;
    reg_idx_t   rm;
    word_t      rn_val;
    word_t      rm_val;
    // operand2 holds an immediate rather than the rm value
    logic       op2_imm;
    word_t      operand2;
    word_t      pc;
    word_t      offset;
    reg_idx_t   rd;
    logic       write_reg;
  } decode_out_t;

  typedef struct packed {
    logic     valid;
    logic     write_reg;
    reg_idx_t rd;
    word_t    result;
    logic     store_en;
    logic     load_en;
    word_t    addr;
    word_t    store_data;
  } exec_out_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    word_t    data;
  } retire_t;

  typedef struct packed {
    logic  valid;
    word_t addr;
    word_t data;
  } store_t;

endpackage

`default_nettype wire

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
  parameter int code_words = 32
) (
  input  wire                       clk,
  input  wire                       nreset,
  input  wire cpu_pkg::prog_write_t prog,
  input  wire                       run,
  input  wire                       redirect_en,
  input  wire cpu_pkg::word_t       redirect_pc,
  input  wire                       flush,
  output cpu_pkg::word_t            fetch_inst,
  output cpu_pkg::word_t            fetch_pc,
  output logic                      fetch_valid
);
  import cpu_pkg::*;

  localparam int code_aw = $clog2(code_words);

  word_t code_mem [code_words];
  word_t pc;

  // program load, one word per strobe
  always_ff @(posedge clk) begin
    if (prog.en) begin
      code_mem[prog.addr[code_aw-1:0]] <= prog.data;
    end
  end

  // pc holds while idle, a taken branch overrides the step
  always_ff @(posedge clk) begin
    if (!nreset) begin
      pc <= '0;
    end else if (redirect_en) begin
      pc <= redirect_pc;
    end else if (run) begin
      pc <= pc + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    fetch_inst <= code_mem[pc[2 +: code_aw]];
    fetch_pc   <= pc;
    if (!nreset) begin
      fetch_valid <= 1'b0;
    end else begin
      fetch_valid <= run && !flush;
    end
  end

  prog_only_idle: assert property (@(posedge clk) disable iff (!nreset)
    prog.en |-> !run)
    else $error("program write while the core is running");

endmodule

`default_nettype wire

// ==== hw/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  wire                    clk,
  input  wire                    nreset,
  input  wire cpu_pkg::reg_idx_t rs1,
  input  wire cpu_pkg::reg_idx_t rs2,
  input  wire                    we,
  input  wire cpu_pkg::reg_idx_t ws,
  input  wire cpu_pkg::word_t    wd,
  output cpu_pkg::word_t         d1,
  output cpu_pkg::word_t         d2
);
  import cpu_pkg::*;

  // r15 is the pc and has no storage here
  word_t regs [15];

  always_ff @(posedge clk) begin
    if (!nreset) begin
      for (int i = 0; i < 15; i++) begin
        regs[i] <= '0;
      end
    end else if (we && ws != reg_pc) begin
      regs[ws] <= wd;
    end
  end

  // write-through so decode sees this cycle's write-back
  function automatic word_t read_reg(input reg_idx_t rs);
    if (we && ws == rs) begin
      return wd;
    end else if (rs == reg_pc) begin
      return '0;
    end
    return regs[rs];
  endfunction

  always_comb begin
    d1 = read_reg(rs1);
    d2 = read_reg(rs2);
  end

  no_pc_write: assert property (@(posedge clk) disable iff (!nreset)
    we |-> ws != reg_pc)
    else $error("write-back targets r15");

endmodule

`default_nettype wire

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  wire                     clk,
  input  wire                     nreset,
  input  wire                     flush,
  input  wire cpu_pkg::word_t     fetch_inst,
  input  wire cpu_pkg::word_t     fetch_pc,
  input  wire                     fetch_valid,
  input  wire cpu_pkg::word_t     d1,
  input  wire cpu_pkg::word_t     d2,
  output cpu_pkg::reg_idx_t       rs1,
  output cpu_pkg::reg_idx_t       rs2,
  output cpu_pkg::decode_out_t    dec
);
  import cpu_pkg::*;

  inst_kind_e  kind;
  decode_out_t dec_d;

  // opcodes that produce a register result
  function automatic logic writes_rd(input opcode_e op);
    case (op)
      op_and, op_eor, op_sub, op_add,
      op_orr, op_mov, op_bic, op_mvn: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  assign kind = inst_kind_e'(fetch_inst[27:26]);
  assign rs1  = fetch_inst[19:16];
  // a store reads its data register rd through the second port
  assign rs2  = (kind == kind_ldr_str) ? fetch_inst[15:12] : fetch_inst[3:0];

  ////////////////////////////////////////////////////////////////////////////
  // field decode and operand selection

  always_comb begin
    dec_d           = '0;
    dec_d.valid     = fetch_valid;
    dec_d.kind      = kind;
    dec_d.opcode    = opcode_e'(fetch_inst[24:21]);
    dec_d.cond      = cond_e'(fetch_inst[31:28]);
    // cmp sets flags whatever its S bit says
    dec_d.set_flags = kind == kind_data_proc &&
                      (fetch_inst[20] || dec_d.opcode == op_cmp);
    dec_d.is_load   = kind == kind_ldr_str && fetch_inst[20];
    dec_d.is_link   = kind == kind_branch && fetch_inst[24];
    dec_d.rn        = rs1;
    dec_d.rm        = rs2;
    dec_d.rd        = dec_d.is_link ? reg_link : fetch_inst[15:12];
    dec_d.pc        = fetch_pc;
    dec_d.offset    = {{6{fetch_inst[23]}}, fetch_inst[23:0], 2'b00};

    // r15 reads see the instruction address plus 8
    dec_d.rn_val = (rs1 == reg_pc) ? fetch_pc + 32'd8 : d1;
    dec_d.rm_val = (rs2 == reg_pc) ? fetch_pc + 32'd8 : d2;

    dec_d.op2_imm = kind != kind_data_proc || fetch_inst[25];
    if (kind == kind_ldr_str) begin
      dec_d.operand2 = {20'd0, fetch_inst[11:0]};
    end else if (fetch_inst[25]) begin
      dec_d.operand2 = {24'd0, fetch_inst[7:0]};
    end else begin
      dec_d.operand2 = dec_d.rm_val;
    end

    // writes to r15 are dropped
    case (kind)
      kind_data_proc: dec_d.write_reg = writes_rd(dec_d.opcode) && dec_d.rd != reg_pc;
      kind_ldr_str:   dec_d.write_reg = dec_d.is_load && dec_d.rd != reg_pc;
      kind_branch:    dec_d.write_reg = dec_d.is_link;
      default:        dec_d.write_reg = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // decode register

  always_ff @(posedge clk) begin
    dec <= dec_d;
    if (!nreset || flush) begin
      dec.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  wire                      clk,
  input  wire                      nreset,
  input  wire cpu_pkg::decode_out_t dec,
  input  wire cpu_pkg::exec_out_t  mem_fwd,
  input  wire cpu_pkg::retire_t    wb_fwd,
  output logic                     flush,
  output logic                     redirect_en,
  output cpu_pkg::word_t           redirect_pc,
  output cpu_pkg::exec_out_t       ex
);
  import cpu_pkg::*;

  flags_t      flags;
  word_t       a;
  word_t       b;
  word_t       op2;
  logic [32:0] alu;
  logic        taken;
  exec_out_t   ex_d;

  // newest producer wins, memory stage before write-back
  function automatic word_t forward(input reg_idx_t idx, input word_t val);
    if (mem_fwd.valid && mem_fwd.write_reg && mem_fwd.rd == idx) begin
      return mem_fwd.result;
    end else if (wb_fwd.valid && wb_fwd.rd == idx) begin
      return wb_fwd.data;
    end
    return val;
  endfunction

  function automatic logic cond_pass(input cond_e cond, input flags_t f);
    case (cond)
      cond_eq: return f.z;
      cond_ne: return !f.z;
      cond_cs: return f.c;
      cond_cc: return !f.c;
      cond_mi: return f.n;
      cond_pl: return !f.n;
      cond_al: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  always_comb begin
    a   = forward(dec.rn, dec.rn_val);
    b   = forward(dec.rm, dec.rm_val);
    op2 = dec.op2_imm ? dec.operand2 : b;
  end

  ////////////////////////////////////////////////////////////////////////////
  // ALU, bit 32 is the carry out

  always_comb begin
    case (dec.opcode)
      op_and:         alu = {1'b0, a & op2};
      op_eor:         alu = {1'b0, a ^ op2};
      // carry set means no borrow
      op_sub, op_cmp: alu = {1'b0, a} + {1'b0, ~op2} + 33'd1;
      op_add:         alu = {1'b0, a} + {1'b0, op2};
      op_orr:         alu = {1'b0, a | op2};
      op_mov:         alu = {1'b0, op2};
      op_bic:         alu = {1'b0, a & ~op2};
      op_mvn:         alu = {1'b0, ~op2};
      default:        alu = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!nreset) begin
      flags <= '0;
    end else if (dec.valid && dec.set_flags) begin
      flags.n <= alu[31];
      flags.z <= alu[31:0] == 32'd0;
      flags.c <= alu[32];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // branch resolution

  assign taken       = dec.valid && dec.kind == kind_branch && cond_pass(dec.cond, flags);
  assign redirect_en = taken;
  assign flush       = taken;
  assign redirect_pc = dec.pc + 32'd8 + dec.offset;

  always_comb begin
    ex_d.valid      = dec.valid;
    // a BL links only when its branch is taken
    ex_d.write_reg  = dec.write_reg && (dec.kind != kind_branch || taken);
    ex_d.rd         = dec.rd;
    ex_d.addr       = a + dec.operand2;
    ex_d.store_data = b;
    ex_d.load_en    = dec.is_load;
    ex_d.store_en   = dec.kind == kind_ldr_str && !dec.is_load;
    case (dec.kind)
      // BL links to the next instruction
      kind_branch:  ex_d.result = dec.pc + 32'd4;
      kind_ldr_str: ex_d.result = ex_d.addr;
      default:      ex_d.result = alu[31:0];
    endcase
  end

  always_ff @(posedge clk) begin
    ex <= ex_d;
    if (!nreset) begin
      ex.valid <= 1'b0;
    end
  end

  // the instruction behind a taken branch must be gone next cycle
  branch_squash: assert property (@(posedge clk) disable iff (!nreset)
    redirect_en |=> !dec.valid)
    else $error("instruction after a taken branch was not flushed");

endmodule

`default_nettype wire

// ==== hw/result_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_stage #(
  parameter int data_words = 16
) (
  input  wire                     clk,
  input  wire                     nreset,
  input  wire cpu_pkg::exec_out_t ex,
  output cpu_pkg::exec_out_t      mem_fwd,
  output logic                    we,
  output cpu_pkg::reg_idx_t       ws,
  output cpu_pkg::word_t          wd,
  output cpu_pkg::retire_t        retire,
  output cpu_pkg::store_t         store
);
  import cpu_pkg::*;

  localparam int data_aw = $clog2(data_words);

  word_t              data_mem [data_words];
  logic [data_aw-1:0] idx;

  // word index, wraps at data_words
  assign idx = ex.addr[2 +: data_aw];

  ////////////////////////////////////////////////////////////////////////////
  // memory stage

  always_ff @(posedge clk) begin
    if (ex.valid && ex.store_en) begin
      data_mem[idx] <= ex.store_data;
    end
  end

  // load data is ready in the same cycle, also for forwarding
  always_comb begin
    mem_fwd = ex;
    if (ex.load_en) begin
      mem_fwd.result = data_mem[idx];
    end
  end

  assign store.valid = ex.valid && ex.store_en;
  assign store.addr  = word_t'(idx);
  assign store.data  = ex.store_data;

  ////////////////////////////////////////////////////////////////////////////
  // write-back

  always_ff @(posedge clk) begin
    retire.rd   <= ex.rd;
    retire.data <= mem_fwd.result;
    if (!nreset) begin
      retire.valid <= 1'b0;
    end else begin
      retire.valid <= ex.valid && ex.write_reg;
    end
  end

  assign we = retire.valid;
  assign ws = retire.rd;
  assign wd = retire.data;

  store_or_write: assert property (@(posedge clk) disable iff (!nreset)
    ex.valid |-> !(ex.store_en && ex.write_reg))
    else $error("store decoded with a register write");

endmodule

`default_nettype wire

// ==== hw/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
  parameter int code_words = 32,
  parameter int data_words = 16
) (
  input  wire                       clk,
  input  wire                       nreset,
  input  wire cpu_pkg::prog_write_t prog,
  input  wire                       run,
  output cpu_pkg::retire_t          retire,
  output cpu_pkg::store_t           store
);
  import cpu_pkg::*;

  word_t       fetch_inst;
  word_t       fetch_pc;
  logic        fetch_valid;
  logic        flush;
  logic        redirect_en;
  word_t       redirect_pc;
  reg_idx_t    rs1;
  reg_idx_t    rs2;
  word_t       d1;
  word_t       d2;
  decode_out_t dec;
  exec_out_t   ex;
  exec_out_t   mem_fwd;
  logic        we;
  reg_idx_t    ws;
  word_t       wd;

  fetch_stage #(
    .code_words (code_words)
  ) u_fetch (
    .clk         (clk),
    .nreset      (nreset),
    .prog        (prog),
    .run         (run),
    .redirect_en (redirect_en),
    .redirect_pc (redirect_pc),
    .flush       (flush),
    .fetch_inst  (fetch_inst),
    .fetch_pc    (fetch_pc),
    .fetch_valid (fetch_valid)
  );

  register_file u_regs (
    .clk    (clk),
    .nreset (nreset),
    .rs1    (rs1),
    .rs2    (rs2),
    .we     (we),
    .ws     (ws),
    .wd     (wd),
    .d1     (d1),
    .d2     (d2)
  );

  decode_stage u_decode (
    .clk         (clk),
    .nreset      (nreset),
    .flush       (flush),
    .fetch_inst  (fetch_inst),
    .fetch_pc    (fetch_pc),
    .fetch_valid (fetch_valid),
    .d1          (d1),
    .d2          (d2),
    .rs1         (rs1),
    .rs2         (rs2),
    .dec         (dec)
  );

  // write-back forwarding comes straight from the retire port
  execute_stage u_execute (
    .clk         (clk),
    .nreset      (nreset),
    .dec         (dec),
    .mem_fwd     (mem_fwd),
    .wb_fwd      (retire),
    .flush       (flush),
    .redirect_en (redirect_en),
    .redirect_pc (redirect_pc),
    .ex          (ex)
  );

  result_stage #(
    .data_words (data_words)
  ) u_result (
    .clk     (clk),
    .nreset  (nreset),
    .ex      (ex),
    .mem_fwd (mem_fwd),
    .we      (we),
    .ws      (ws),
    .wd      (wd),
    .retire  (retire),
    .store   (store)
  );

endmodule

`default_nettype wire

// ==== verif/cpu_model.svh ====
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// in-order reference, included inside cpu_tb
// walks prog_mem one instruction at a time and queues every register
// write and every store the core should produce

// guards against a program that never reaches its closing self branch
localparam int model_step_limit = 4096;

function automatic void queue_reg_write(input reg_idx_t rd, input word_t data);
  retire_t r;
  r.valid = 1'b1;
  r.rd    = rd;
  r.data  = data;
  exp_retire.push_back(r);
endfunction

function automatic void queue_store(input int widx, input word_t data);
  store_t s;
  s.valid = 1'b1;
  s.addr  = word_t'(widx);
  s.data  = data;
  exp_store.push_back(s);
endfunction

function automatic logic cond_holds(input cond_e cond, input logic n, input logic z,
                                    input logic c);
  case (cond)
    cond_eq: return z;
    cond_ne: return !z;
    cond_cs: return c;
    cond_cc: return !c;
    cond_mi: return n;
    cond_pl: return !n;
    cond_al: return 1'b1;
    default: return 1'b0;
  endcase
endfunction

function automatic void run_model();
  word_t       regs [16];
  word_t       mem [data_depth];
  word_t       pc;
  word_t       pc_next;
  word_t       inst;
  word_t       a;
  word_t       b;
  word_t       addr;
  word_t       target;
  logic [32:0] wide;
  logic        n_flag;
  logic        z_flag;
  logic        c_flag;
  logic        carry;
  logic        writes;
  logic        done;
  opcode_e     op;
  reg_idx_t    rd;
  int          widx;
  int          steps;

  foreach (regs[i]) regs[i] = '0;
  foreach (mem[i]) mem[i] = '0;
  pc     = '0;
  n_flag = 1'b0;
  z_flag = 1'b0;
  c_flag = 1'b0;
  done   = 1'b0;
  steps  = 0;

  while (!done && steps < model_step_limit) begin
    inst    = prog_mem[(pc >> 2) % code_depth];
    rd      = inst[15:12];
    pc_next = pc + 32'd4;
    // r15 reads see the instruction address plus 8
    a = (inst[19:16] == reg_pc) ? pc + 32'd8 : regs[inst[19:16]];
    b = (inst[3:0] == reg_pc) ? pc + 32'd8 : regs[inst[3:0]];
    steps++;

    case (inst[27:26])
      2'b10: begin
        target = pc + 32'd8 + {{6{inst[23]}}, inst[23:0], 2'b00};
        if (cond_holds(cond_e'(inst[31:28]), n_flag, z_flag, c_flag)) begin
          if (inst[24]) begin
            regs[reg_link] = pc + 32'd4;
            queue_reg_write(reg_link, pc + 32'd4);
          end
          done    = target == pc;
          pc_next = target;
        end
      end
      2'b01: begin
        addr = a + {20'd0, inst[11:0]};
        widx = int'((addr >> 2) % data_depth);
        if (inst[20]) begin
          if (rd != reg_pc) begin
            regs[rd] = mem[widx];
            queue_reg_write(rd, mem[widx]);
          end
        end else begin
          mem[widx] = (rd == reg_pc) ? pc + 32'd8 : regs[rd];
          queue_store(widx, mem[widx]);
        end
      end
      2'b00: begin
        if (inst[25]) begin
          b = {24'd0, inst[7:0]};
        end
        op     = opcode_e'(inst[24:21]);
        writes = op != op_cmp;
        carry  = 1'b0;
        case (op)
          op_and: wide = {1'b0, a & b};
          op_eor: wide = {1'b0, a ^ b};
          op_sub, op_cmp: begin
            wide  = {1'b0, a} - {1'b0, b};
            carry = a >= b;
          end
          op_add: begin
            wide  = {1'b0, a} + {1'b0, b};
            carry = wide[32];
          end
          op_orr: wide = {1'b0, a | b};
          op_mov: wide = {1'b0, b};
          op_bic: wide = {1'b0, a & ~b};
          op_mvn: wide = {1'b0, ~b};
          default: begin
            wide   = '0;
            writes = 1'b0;
          end
        endcase
        if (inst[20] || op == op_cmp) begin
          n_flag = wide[31];
          z_flag = wide[31:0] == 32'd0;
          c_flag = carry;
        end
        if (writes && rd != reg_pc) begin
          regs[rd] = wide[31:0];
          queue_reg_write(rd, wide[31:0]);
        end
      end
      default: ;
    endcase
    pc = pc_next;
  end
endfunction

`endif

// ==== verif/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
  import cpu_pkg::*;

  localparam int code_depth      = 64;
  localparam int data_depth      = 16;
  localparam int cycles_per_inst = 60;

  logic        clk;
  logic        nreset;
  logic        run;
  prog_write_t prog;
  retire_t     retire;
  store_t      store;

  word_t   prog_mem [code_depth];
  int      prog_len;
  retire_t exp_retire [$];
  store_t  exp_store [$];
  int      seed;
  int      checked;

  `include "cpu_model.svh"

  cpu_top #(
    .code_words (code_depth),
    .data_words (data_depth)
  ) dut_i (
    .clk    (clk),
    .nreset (nreset),
    .prog   (prog),
    .run    (run),
    .retire (retire),
    .store  (store)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // checking

  task automatic stop_with_failure();
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic compare_retire(input retire_t got, input retire_t exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: write-back r%0d = %h, expected r%0d = %h",
               $time, got.rd, got.data, exp.rd, exp.data);
      stop_with_failure();
    end else begin
      checked++;
    end
  endtask

  task automatic compare_store(input store_t got, input store_t exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: store word %0d = %h, expected word %0d = %h",
               $time, got.addr, got.data, exp.addr, exp.data);
      stop_with_failure();
    end else begin
      checked++;
    end
  endtask

  // outputs are settled by the falling edge
  always @(negedge clk) begin
    if (retire.valid) begin
      if (!nreset || !run) begin
        $display("write-back seen while the core was held idle at %0t ns", $time);
        stop_with_failure();
      end else if (exp_retire.size() == 0) begin
        $display("write-back of r%0d seen with none expected at %0t ns", retire.rd, $time);
        stop_with_failure();
      end else begin
        compare_retire(retire, exp_retire.pop_front());
      end
    end
  end

  always @(negedge clk) begin
    if (store.valid) begin
      if (!nreset || !run) begin
        $display("store seen while the core was held idle at %0t ns", $time);
        stop_with_failure();
      end else if (exp_store.size() == 0) begin
        $display("store to word %0d seen with none expected at %0t ns", store.addr, $time);
        stop_with_failure();
      end else begin
        compare_store(store, exp_store.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // instruction encoding and program building

  function automatic word_t dp_imm(input opcode_e op, input logic s, input reg_idx_t rd,
                                   input reg_idx_t rn, input logic [7:0] imm);
    return {cond_al, 3'b001, op, s, rn, rd, 4'h0, imm};
  endfunction

  function automatic word_t dp_reg(input opcode_e op, input logic s, input reg_idx_t rd,
                                   input reg_idx_t rn, input reg_idx_t rm);
    return {cond_al, 3'b000, op, s, rn, rd, 8'h00, rm};
  endfunction

  // pre-indexed, offset added, word access, no write-back
  function automatic word_t mem_inst(input logic load, input reg_idx_t rd,
                                     input reg_idx_t rn, input logic [11:0] offset);
    return {cond_al, 3'b010, 4'b1100, load, rn, rd, offset};
  endfunction

  // target is the branch address plus 8 plus words * 4
  function automatic word_t branch_inst(input cond_e cond, input logic link, input int words);
    logic [23:0] off;
    off = 24'(words);
    return {cond, 3'b101, link, off};
  endfunction

  function automatic int rand_below(input int n);
    int v;
    v = $random(seed);
    return int'($unsigned(v) % $unsigned(n));
  endfunction

  function automatic opcode_e pick_opcode(input int k);
    case (k)
      0: return op_and;
      1: return op_eor;
      2: return op_sub;
      3: return op_add;
      4: return op_orr;
      5: return op_mov;
      6: return op_bic;
      7: return op_mvn;
      default: return op_cmp;
    endcase
  endfunction

  function automatic cond_e pick_cond(input int k);
    case (k)
      0: return cond_eq;
      1: return cond_ne;
      2: return cond_cs;
      3: return cond_cc;
      4: return cond_mi;
      default: return cond_pl;
    endcase
  endfunction

  task automatic add_inst(input word_t w);
    prog_mem[prog_len] = w;
    prog_len++;
  endtask

  // every condition once, each skipping two increments when taken
  task automatic add_branch_cases();
    for (int k = 0; k < 6; k++) begin
      add_inst(branch_inst(pick_cond(k), 1'b0, 1));
      add_inst(dp_imm(op_add, 1'b0, 4'd2, 4'd2, 8'd1));
      add_inst(dp_imm(op_add, 1'b0, 4'd3, 4'd3, 8'd1));
    end
  endtask

  // r8 stays zero and serves as the load/store base
  task automatic build_random_program();
    logic     written [data_depth];
    int       word;
    reg_idx_t rn;
    foreach (written[i]) written[i] = 1'b0;
    prog_len = 0;
    for (int i = 0; i < 40; i++) begin
      word = rand_below(data_depth);
      rn   = reg_idx_t'(rand_below(9));
      if (rn == 4'd8) begin
        rn = reg_pc;
      end
      if (rand_below(4) == 0) begin
        // loads only touch words already stored in this program
        if (written[word] && rand_below(2) == 0) begin
          add_inst(mem_inst(1'b1, reg_idx_t'(rand_below(8)), 4'd8, 12'(word * 4)));
        end else begin
          written[word] = 1'b1;
          add_inst(mem_inst(1'b0, reg_idx_t'(rand_below(8)), 4'd8, 12'(word * 4)));
        end
      end else if (rand_below(2) == 0) begin
        add_inst(dp_imm(pick_opcode(rand_below(9)), 1'(rand_below(2)),
                        reg_idx_t'(rand_below(8)), rn, 8'(rand_below(256))));
      end else begin
        add_inst(dp_reg(pick_opcode(rand_below(9)), 1'(rand_below(2)),
                        reg_idx_t'(rand_below(8)), rn, reg_idx_t'(rand_below(8))));
      end
    end
    add_inst(branch_inst(cond_al, 1'b0, -2));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // running one program

  task automatic run_program();
    int cycles;
    int limit;
    run_model();
    limit = cycles_per_inst * prog_len;
    @(posedge clk);
    nreset <= 1'b0;
    run    <= 1'b0;
    repeat (16) @(posedge clk);
    nreset <= 1'b1;
    for (int i = 0; i < prog_len; i++) begin
      @(posedge clk);
      prog <= '{en: 1'b1, addr: 8'(i), data: prog_mem[i]};
    end
    @(posedge clk);
    prog <= '0;
    @(posedge clk);
    run <= 1'b1;
    cycles = 0;
    while ((exp_retire.size() != 0 || exp_store.size() != 0) && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (exp_retire.size() != 0 || exp_store.size() != 0) begin
      $display("timeout after %0d cycles, %0d write-backs and %0d stores never arrived",
               cycles, exp_retire.size(), exp_store.size());
      stop_with_failure();
    end else begin
      // any extra output while the core spins is flagged by the compare blocks
      repeat (8) @(posedge clk);
      run <= 1'b0;
      repeat (4) @(posedge clk);
    end
  endtask

  initial begin
    clk     = 1'b0;
    nreset  = 1'b0;
    run     = 1'b0;
    prog    = '0;
    seed    = 34;
    checked = 0;

    // dependent chain through every writing opcode
    prog_len = 0;
    add_inst(dp_imm(op_mov, 1'b0, 4'd1, 4'd0, 8'd5));
    add_inst(dp_imm(op_add, 1'b0, 4'd2, 4'd1, 8'd3));
    add_inst(dp_imm(op_sub, 1'b0, 4'd3, 4'd2, 8'd1));
    add_inst(dp_imm(op_and, 1'b0, 4'd4, 4'd3, 8'd6));
    add_inst(dp_imm(op_orr, 1'b0, 4'd5, 4'd4, 8'd9));
    add_inst(dp_imm(op_eor, 1'b0, 4'd6, 4'd5, 8'hff));
    add_inst(dp_imm(op_bic, 1'b0, 4'd7, 4'd6, 8'h0f));
    add_inst(dp_imm(op_mvn, 1'b0, 4'd9, 4'd0, 8'h12));
    add_inst(dp_reg(op_add, 1'b0, 4'd10, 4'd9, 4'd7));
    add_inst(branch_inst(cond_al, 1'b0, -2));
    run_program();

    // store, load back at once, then use the loaded value
    prog_len = 0;
    add_inst(dp_imm(op_mov, 1'b0, 4'd1, 4'd0, 8'h5a));
    add_inst(dp_imm(op_mov, 1'b0, 4'd2, 4'd0, 8'd8));
    add_inst(mem_inst(1'b0, 4'd1, 4'd2, 12'd4));
    add_inst(mem_inst(1'b1, 4'd3, 4'd2, 12'd4));
    add_inst(dp_imm(op_add, 1'b0, 4'd4, 4'd3, 8'd1));
    add_inst(mem_inst(1'b0, 4'd4, 4'd2, 12'd8));
    add_inst(branch_inst(cond_al, 1'b0, -2));
    run_program();

    // conditions after an equal compare, then after a negative subs
    prog_len = 0;
    add_inst(dp_imm(op_mov, 1'b0, 4'd1, 4'd0, 8'd3));
    add_inst(dp_imm(op_cmp, 1'b0, 4'd0, 4'd1, 8'd3));
    add_branch_cases();
    add_inst(dp_imm(op_sub, 1'b1, 4'd5, 4'd1, 8'd4));
    add_branch_cases();
    add_inst(branch_inst(cond_al, 1'b0, -2));
    run_program();

    // BL on a failed condition, BL over two increments, r15 reads and a dropped r15 write
    prog_len = 0;
    add_inst(dp_imm(op_mov, 1'b0, 4'd1, 4'd0, 8'd1));
    add_inst(branch_inst(cond_eq, 1'b1, 2));
    add_inst(branch_inst(cond_al, 1'b1, 2));
    add_inst(dp_imm(op_add, 1'b0, 4'd2, 4'd2, 8'd1));
    add_inst(dp_imm(op_add, 1'b0, 4'd3, 4'd3, 8'd1));
    add_inst(branch_inst(cond_al, 1'b0, -2));
    add_inst(dp_imm(op_add, 1'b0, 4'd4, reg_pc, 8'd0));
    add_inst(dp_reg(op_mov, 1'b0, 4'd5, 4'd0, reg_link));
    add_inst(dp_reg(op_add, 1'b0, 4'd6, reg_pc, reg_pc));
    add_inst(dp_imm(op_mov, 1'b0, reg_pc, 4'd0, 8'd0));
    add_inst(dp_imm(op_add, 1'b0, 4'd7, 4'd6, 8'd1));
    add_inst(branch_inst(cond_al, 1'b0, -2));
    run_program();

    build_random_program();
    run_program();

    if (checked == 0) begin
      $display("no results were compared");
      stop_with_failure();
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+verif
hw/cpu_pkg.sv
hw/fetch_stage.sv
hw/register_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/cpu_top.sv
verif/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the cpu testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module cpu_tb -f all.f -o cpu_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/cpu_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "No errors"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1
